// File: Makefile
# Verilator build and run of the link receiver testbench
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = link_rx_tb
FILELIST  = link_rx.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/beat_fifo.sv
// Synchronous single-clock beat FIFO with show-ahead head.
// Depth must be a power of two. A write is readable on rd_data the next cycle.
// No full flag; the sender's credits keep the FIFO from overflowing.
module beat_fifo
   #(parameter int depth = 4)
   (
   input  logic               clk,
   input  logic               nreset,
   input  logic               wr_en,
   input  link_rx_pkg::beat_t wr_data,
   input  logic               rd_en,
   output link_rx_pkg::beat_t rd_data,
   output logic               empty
   );
   import link_rx_pkg::*;

   localparam int aw = $clog2(depth);

   beat_t       mem [depth];
   logic [aw:0] wr_ptr;       // Extra MSB for wrap
   logic [aw:0] rd_ptr;
   logic        rd_ok;

   assign empty   = (wr_ptr == rd_ptr);
   assign rd_ok   = rd_en & !empty;          // Ignore reads when empty
   assign rd_data = mem[rd_ptr[aw-1:0]];     // Head always visible

   // Storage
   always_ff @(posedge clk)
      if (wr_en)
         mem[wr_ptr[aw-1:0]] <= wr_data;

   // Pointers
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
      end

endmodule

// File: hw/credit_tracker.sv
// Local and remote credit bookkeeping.
// Local counters add one per beat drained from the request and response FIFOs
// and reload their init values while csr_en is low. Remote credits come from
// link packets whose subtype names the request or response channel.
module credit_tracker
   (
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 csr_en,
   input  link_rx_pkg::credit_t csr_crdt_req_init,
   input  link_rx_pkg::credit_t csr_crdt_resp_init,
   input  logic                 rd_req,
   input  logic                 rd_resp,
   input  logic                 lnk_done,
   input  link_rx_pkg::beat_t   lnk_cmd,
   output link_rx_pkg::credit_t loc_crdt_req,
   output link_rx_pkg::credit_t loc_crdt_resp,
   output link_rx_pkg::credit_t rmt_crdt_req,
   output link_rx_pkg::credit_t rmt_crdt_resp
   );
   import link_rx_pkg::*;

   logic       lnk_ok;       // Real link opcode, not undefined
   logic [7:0] subtype;
   credit_t    credit_in;

   assign lnk_ok    = lnk_done & (opcode_t'(lnk_cmd[2:0]) == op_link);
   assign subtype   = lnk_cmd[15:8];
   assign credit_in = lnk_cmd[31:16];

   //########################################
   // Local counters
   //########################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         loc_crdt_req  <= '0;
         loc_crdt_resp <= '0;
      end
      else if (!csr_en)
      begin
         loc_crdt_req  <= csr_crdt_req_init;    // Load while disabled
         loc_crdt_resp <= csr_crdt_resp_init;
      end
      else
      begin
         if (rd_req)
            loc_crdt_req <= loc_crdt_req + 16'd1;
         if (rd_resp)
            loc_crdt_resp <= loc_crdt_resp + 16'd1;
      end

   // Remote credits from link packets
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         rmt_crdt_req  <= '0;
         rmt_crdt_resp <= '0;
      end
      else
      begin
         if (lnk_ok && subtype == subtype_crdt_req)
            rmt_crdt_req <= credit_in;
         if (lnk_ok && subtype == subtype_crdt_resp)
            rmt_crdt_resp <= credit_in;
      end

endmodule

// File: hw/link_rx.sv
// Link-layer packet receiver top level.
// Takes one 32-bit beat per cycle from the PHY and delivers rebuilt packets on
// separate request and response ports with valid/ready; link packets update credits.
module link_rx
   (
   input  logic                           clk,
   input  logic                           nreset,
   // PHY side, sender obeys credits so there is no ready
   input  link_rx_pkg::beat_t             phy_rxdata,
   input  logic                           phy_rxvld,
   // Credit control
   input  logic                           csr_en,
   input  link_rx_pkg::credit_t           csr_crdt_req_init,
   input  link_rx_pkg::credit_t           csr_crdt_resp_init,
   output link_rx_pkg::credit_t           loc_crdt_req,
   output link_rx_pkg::credit_t           loc_crdt_resp,
   output link_rx_pkg::credit_t           rmt_crdt_req,
   output link_rx_pkg::credit_t           rmt_crdt_resp,
   // Request port
   output logic [link_rx_pkg::cmd_w-1:0]  req_cmd,
   output link_rx_pkg::addr_t             req_dstaddr,
   output link_rx_pkg::addr_t             req_srcaddr,
   output link_rx_pkg::data_t             req_data,
   output logic                           req_valid,
   input  logic                           req_ready,
   // Response port
   output logic [link_rx_pkg::cmd_w-1:0]  resp_cmd,
   output link_rx_pkg::addr_t             resp_dstaddr,
   output link_rx_pkg::addr_t             resp_srcaddr,
   output link_rx_pkg::data_t             resp_data,
   output logic                           resp_valid,
   input  logic                           resp_ready
   );
   import link_rx_pkg::*;

   beat_t wr_data;                        // Sampled beat into FIFOs
   logic  wr_req, wr_resp, wr_lnk;
   logic  rd_req, rd_resp, rd_lnk;
   logic  empty_req, empty_resp, empty_lnk;
   beat_t head_req, head_resp, head_lnk;  // Show-ahead heads
   beat_t beat_data;
   logic  beat_vld, beat_first, beat_last;
   logic  busy;                           // Output packet pending
   logic  lnk_done;
   beat_t lnk_cmd;

   //########################################
   // Ingress and class FIFOs
   //########################################
   rx_ingress ingress (.clk, .nreset, .phy_rxdata, .phy_rxvld,
                       .wr_data, .wr_req, .wr_resp, .wr_lnk);

   beat_fifo #(.depth(fifo_depth_data)) req_fifo (
      .clk, .nreset, .wr_en(wr_req), .wr_data, .rd_en(rd_req),
      .rd_data(head_req), .empty(empty_req));

   beat_fifo #(.depth(fifo_depth_data)) resp_fifo (
      .clk, .nreset, .wr_en(wr_resp), .wr_data, .rd_en(rd_resp),
      .rd_data(head_resp), .empty(empty_resp));

   beat_fifo #(.depth(fifo_depth_link)) lnk_fifo (   // Small, link pkts are 1 beat
      .clk, .nreset, .wr_en(wr_lnk), .wr_data, .rd_en(rd_lnk),
      .rd_data(head_lnk), .empty(empty_lnk));

   //########################################
   // Drain, rebuild and credits
   //########################################
   rx_sequencer sequencer (
      .clk, .nreset, .empty_req, .empty_resp, .empty_lnk,
      .head_req, .head_resp, .head_lnk, .busy,
      .rd_req, .rd_resp, .rd_lnk, .beat_data, .beat_vld, .beat_first, .beat_last);

   packet_assembler assembler (
      .clk, .nreset, .beat_data, .beat_vld, .beat_first, .beat_last,
      .req_ready, .resp_ready, .busy,
      .req_cmd, .req_dstaddr, .req_srcaddr, .req_data, .req_valid,
      .resp_cmd, .resp_dstaddr, .resp_srcaddr, .resp_data, .resp_valid,
      .lnk_done, .lnk_cmd);

   credit_tracker credits (
      .clk, .nreset, .csr_en, .csr_crdt_req_init, .csr_crdt_resp_init,
      .rd_req, .rd_resp, .lnk_done, .lnk_cmd,
      .loc_crdt_req, .loc_crdt_resp, .rmt_crdt_req, .rmt_crdt_resp);

endmodule

// File: hw/link_rx_pkg.sv
// Common widths, command word layout and decode helpers for the link receiver.
// Every block imports this package. The command word is the first beat of a packet.
package link_rx_pkg;

   //########################################
   // Widths and sizes
   //########################################
   localparam int beat_w     = 32;                  // One PHY beat
   localparam int cmd_w      = 32;
   localparam int addr_w     = 32;
   localparam int data_words = 4;                   // Max payload words
   localparam int data_w     = data_words * beat_w;
   localparam int pkt_words  = 7;                   // Cmd, dst, src, data
   localparam int pkt_w      = pkt_words * beat_w;

   typedef logic [beat_w-1:0] beat_t;
   typedef logic [addr_w-1:0] addr_t;
   typedef logic [data_w-1:0] data_t;
   typedef logic [15:0]       credit_t;
   typedef logic [2:0]        beat_cnt_t;            // Up to 7 beats

   // Opcode in cmd[2:0], codes 6 and 7 undefined
   typedef enum logic [2:0] {
      op_link         = 3'd0,
      op_read         = 3'd1,
      op_write        = 3'd2,
      op_write_posted = 3'd3,
      op_read_resp    = 3'd4,
      op_write_resp   = 3'd5
   } opcode_t;

   typedef enum logic [1:0] {cls_req, cls_resp, cls_link} pkt_class_t;

   localparam logic [7:0] subtype_crdt_req  = 8'h01;   // Link subtype, cmd[15:8]
   localparam logic [7:0] subtype_crdt_resp = 8'h11;

   localparam int fifo_depth_data = 64;
   localparam int fifo_depth_link = 4;

   // Which FIFO a packet belongs to
   function automatic pkt_class_t class_of(input beat_t cmd);
      pkt_class_t cls;
      case (opcode_t'(cmd[2:0]))
         op_read, op_write, op_write_posted: cls = cls_req;
         op_read_resp, op_write_resp:        cls = cls_resp;
         default:                            cls = cls_link;   // Incl. undefined
      endcase
      return cls;
   endfunction

   // Packet length in beats, len field cmd[5:4] is words minus one
   function automatic beat_cnt_t packet_beats(input beat_t cmd);
      beat_cnt_t beats;
      case (opcode_t'(cmd[2:0]))
         op_read, op_write_resp:                  beats = 3'd3;
         op_write, op_write_posted, op_read_resp: beats = 3'd4 + beat_cnt_t'(cmd[5:4]);
         default:                                 beats = 3'd1;
      endcase
      return beats;
   endfunction

endpackage

// File: hw/packet_assembler.sv
// Rebuilds packets from beats and presents them on the request or response port.
// Fields hold until the port's ready is seen; link packets give a lnk_done pulse
// with the command word instead of a valid.
module packet_assembler
   (
   input  logic                          clk,
   input  logic                          nreset,
   input  link_rx_pkg::beat_t            beat_data,
   input  logic                          beat_vld,
   input  logic                          beat_first,
   input  logic                          beat_last,
   input  logic                          req_ready,
   input  logic                          resp_ready,
   output logic                          busy,
   output logic [link_rx_pkg::cmd_w-1:0] req_cmd,
   output link_rx_pkg::addr_t            req_dstaddr,
   output link_rx_pkg::addr_t            req_srcaddr,
   output link_rx_pkg::data_t            req_data,
   output logic                          req_valid,
   output logic [link_rx_pkg::cmd_w-1:0] resp_cmd,
   output link_rx_pkg::addr_t            resp_dstaddr,
   output link_rx_pkg::addr_t            resp_srcaddr,
   output link_rx_pkg::data_t            resp_data,
   output logic                          resp_valid,
   output logic                          lnk_done,
   output link_rx_pkg::beat_t            lnk_cmd
   );
   import link_rx_pkg::*;

   logic [pkt_w-1:0] pkt;        // Cmd | dst | src | data, word 0 at LSB
   beat_cnt_t        wptr;       // Next word slot
   beat_t            cmd_in;     // Command of packet being closed
   pkt_class_t       cls_in;
   logic             close;
   opcode_t          op;
   logic             is_link;
   logic             no_data;
   addr_t            dstaddr;
   addr_t            srcaddr;
   data_t            data;

   // Word write, first beat clears old contents
   always_ff @(posedge clk)
      if (beat_vld)
      begin
         if (beat_first)
            pkt <= {{(pkt_w-beat_w){1'b0}}, beat_data};
         else
            pkt[wptr*beat_w +: beat_w] <= beat_data;
      end

   assign cmd_in = beat_first ? beat_data : pkt[beat_w-1:0];   // 1-beat pkts too
   assign cls_in = class_of(cmd_in);
   assign close  = beat_vld & beat_last;

   //########################################
   // Output handshake
   //########################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         wptr       <= '0;
         req_valid  <= 1'b0;
         resp_valid <= 1'b0;
         lnk_done   <= 1'b0;
      end
      else
      begin
         if (beat_vld)
            wptr <= beat_first ? 3'd1 : wptr + 3'd1;
         req_valid  <= (close & (cls_in == cls_req))  | (req_valid & !req_ready);
         resp_valid <= (close & (cls_in == cls_resp)) | (resp_valid & !resp_ready);
         lnk_done   <= close & (cls_in == cls_link);           // Single pulse
      end

   assign busy = req_valid | resp_valid;   // Stall drain until taken

   // Field masking by opcode
   assign op      = opcode_t'(pkt[2:0]);
   assign is_link = (class_of(pkt[beat_w-1:0]) == cls_link);
   assign no_data = is_link | (op == op_read) | (op == op_write_resp);
   assign dstaddr = is_link ? '0 : pkt[cmd_w +: addr_w];
   assign srcaddr = is_link ? '0 : pkt[cmd_w+addr_w +: addr_w];
   assign data    = no_data ? '0 : pkt[cmd_w+2*addr_w +: data_w];

   // Both ports share the assembled packet, valid tells which owns it
   assign req_cmd      = pkt[cmd_w-1:0];
   assign req_dstaddr  = dstaddr;
   assign req_srcaddr  = srcaddr;
   assign req_data     = data;
   assign resp_cmd     = pkt[cmd_w-1:0];
   assign resp_dstaddr = dstaddr;
   assign resp_srcaddr = srcaddr;
   assign resp_data    = data;
   assign lnk_cmd      = pkt[beat_w-1:0];

endmodule

// File: hw/rx_ingress.sv
// PHY beat sampler and packet steering.
// Registers each beat, finds packet starts by counting beats from the command
// word, and writes every beat of a packet into the FIFO of that packet's class.
module rx_ingress
   (
   input  logic               clk,
   input  logic               nreset,
   input  link_rx_pkg::beat_t phy_rxdata,
   input  logic               phy_rxvld,
   output link_rx_pkg::beat_t wr_data,
   output logic               wr_req,
   output logic               wr_resp,
   output logic               wr_lnk
   );
   import link_rx_pkg::*;

   beat_t      rx_data;     // Sampled PHY beat
   logic       rx_vld;
   beat_cnt_t  remain;      // Beats still due in current packet
   pkt_class_t cls_hold;    // Class latched at start of packet
   pkt_class_t cls;
   logic       sop;

   // Beat register
   always_ff @(posedge clk)
      rx_data <= phy_rxdata;

   // Zero beats left means the sampled beat is a command word
   assign sop = (remain == '0);
   assign cls = sop ? class_of(rx_data) : cls_hold;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         rx_vld   <= 1'b0;
         remain   <= '0;
         cls_hold <= cls_link;
      end
      else
      begin
         rx_vld <= phy_rxvld;
         if (rx_vld)
         begin
            cls_hold <= cls;                                 // Sticky for the packet
            if (sop)
               remain <= packet_beats(rx_data) - 3'd1;       // Rest of packet
            else
               remain <= remain - 3'd1;
         end
      end

   //########################################
   // One FIFO write enable per beat
   //########################################
   assign wr_data = rx_data;
   assign wr_req  = rx_vld & (cls == cls_req);
   assign wr_resp = rx_vld & (cls == cls_resp);
   assign wr_lnk  = rx_vld & (cls == cls_link);

endmodule

// File: hw/rx_sequencer.sv
// FIFO drain control.
// Between packets it picks link, then response, then request, and then stays on
// that FIFO until the whole packet is read, one beat per cycle unless busy.
module rx_sequencer
   (
   input  logic               clk,
   input  logic               nreset,
   input  logic               empty_req,
   input  logic               empty_resp,
   input  logic               empty_lnk,
   input  link_rx_pkg::beat_t head_req,
   input  link_rx_pkg::beat_t head_resp,
   input  link_rx_pkg::beat_t head_lnk,
   input  logic               busy,          // Assembler holds a packet
   output logic               rd_req,
   output logic               rd_resp,
   output logic               rd_lnk,
   output link_rx_pkg::beat_t beat_data,
   output logic               beat_vld,
   output logic               beat_first,
   output logic               beat_last
   );
   import link_rx_pkg::*;

   typedef enum logic [1:0] {sel_idle, sel_lnk, sel_resp, sel_req} sel_t;

   sel_t      sel;       // FIFO locked for current packet
   sel_t      cur;       // FIFO served this cycle
   beat_cnt_t remain;    // Beats left after the current one
   beat_cnt_t total;
   logic      avail;
   logic      rd;
   logic      first;
   logic      last;

   //########################################
   // Arbitration, only at packet boundary
   //########################################
   always_comb
   begin
      cur = sel;
      if (sel == sel_idle)
      begin
         if (!empty_lnk)
            cur = sel_lnk;        // Link first, keeps credits fresh
         else if (!empty_resp)
            cur = sel_resp;
         else if (!empty_req)
            cur = sel_req;
      end
   end

   // Head mux
   assign beat_data = (cur == sel_lnk)  ? head_lnk  :
                      (cur == sel_resp) ? head_resp : head_req;
   assign avail     = (cur == sel_lnk)  ? !empty_lnk  :
                      (cur == sel_resp) ? !empty_resp :
                      (cur == sel_req)  ? !empty_req  : 1'b0;

   assign rd    = avail & !busy;
   assign first = (sel == sel_idle);
   assign total = packet_beats(beat_data);   // Valid only on the first beat
   assign last  = first ? (total == 3'd1) : (remain == 3'd1);

   assign rd_lnk  = rd & (cur == sel_lnk);
   assign rd_resp = rd & (cur == sel_resp);
   assign rd_req  = rd & (cur == sel_req);

   // Beat strobes toward the assembler
   assign beat_vld   = rd;
   assign beat_first = rd & first;
   assign beat_last  = rd & last;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         sel    <= sel_idle;
         remain <= '0;
      end
      else if (rd)
      begin
         if (last)
            sel <= sel_idle;                         // Rearbitrate next cycle
         else
            sel <= cur;
         remain <= first ? total - 3'd1 : remain - 3'd1;
      end

endmodule

// File: link_rx.f
hw/link_rx_pkg.sv
hw/beat_fifo.sv
hw/rx_ingress.sv
hw/rx_sequencer.sv
hw/packet_assembler.sv
hw/credit_tracker.sv
hw/link_rx.sv
tests/link_rx_tb.sv

// File: tests/link_rx_tb.sv
// Table-driven testbench for the link receiver.
// Sends a fixed packet list as PHY beats, checks both output ports against
// per-port queues, then checks remote credits and local beat counts.
module link_rx_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import link_rx_pkg::*;

   typedef struct packed {
      opcode_t    op;
      logic [1:0] len;          // Data words minus one
      addr_t      dst;
      addr_t      src;
      data_t      data;         // Word 0 at LSB
      logic [7:0] subtype;
      credit_t    credit;
      pkt_class_t port;         // Expected destination
   } pkt_entry_t;

   typedef struct packed {
      logic [cmd_w-1:0] cmd;
      addr_t            dst;
      addr_t            src;
      data_t            data;
   } out_pkt_t;

   localparam int      n_pkts    = 13;
   localparam credit_t req_init  = 16'h0100;
   localparam credit_t resp_init = 16'h0200;

   logic             clk = 1'b0;
   logic             nreset;
   beat_t            phy_rxdata;
   logic             phy_rxvld;
   logic             csr_en;
   credit_t          csr_crdt_req_init, csr_crdt_resp_init;
   credit_t          loc_crdt_req, loc_crdt_resp, rmt_crdt_req, rmt_crdt_resp;
   logic [cmd_w-1:0] req_cmd, resp_cmd;
   addr_t            req_dstaddr, req_srcaddr, resp_dstaddr, resp_srcaddr;
   data_t            req_data, resp_data;
   logic             req_valid, req_ready, resp_valid, resp_ready;

   pkt_entry_t pkts [n_pkts];
   out_pkt_t   req_exp [$];          // In table order per port
   out_pkt_t   resp_exp [$];
   out_pkt_t   req_hold_val, resp_hold_val;
   logic       req_held = 1'b0;      // Valid seen without ready
   logic       resp_held = 1'b0;
   int         req_seen = 0, resp_seen = 0;
   int         n_req = 0, n_resp = 0;
   int         checks = 0, errors = 0;
   int         cycles = 0, cycle_limit = 0;
   logic       random_ready = 1'b0;

   link_rx UUT (.*);

   always #5 clk = ~clk;             // 10 ns period

   //########################################
   // Expected values from the packet rules
   //########################################
   function automatic logic has_data(opcode_t op);
      return (op == op_write) || (op == op_write_posted) || (op == op_read_resp);
   endfunction

   function automatic int expected_beats(pkt_entry_t e);
      int beats;
      if (e.op == op_link)
         beats = 1;                  // Command only
      else if (has_data(e.op))
         beats = 4 + int'(e.len);
      else
         beats = 3;                  // Cmd, dst, src
      return beats;
   endfunction

   function automatic beat_t make_cmd(pkt_entry_t e);
      beat_t cmd;
      cmd        = '0;
      cmd[2:0]   = e.op;
      cmd[5:4]   = e.len;
      cmd[15:8]  = e.subtype;
      cmd[31:16] = e.credit;
      return cmd;
   endfunction

   function automatic out_pkt_t expected_out(pkt_entry_t e);
      out_pkt_t o;
      int       i;
      o.cmd  = make_cmd(e);
      o.dst  = e.dst;
      o.src  = e.src;
      o.data = '0;                   // Words not received stay zero
      if (has_data(e.op))
         for (i = 0; i <= int'(e.len); i++)
            o.data[i*beat_w +: beat_w] = e.data[i*beat_w +: beat_w];
      return o;
   endfunction

   function automatic data_t word_run(beat_t base);
      return {base + 32'd3, base + 32'd2, base + 32'd1, base};
   endfunction

   function automatic pkt_entry_t make_entry(opcode_t op, int len, addr_t dst, addr_t src,
                                             data_t data, logic [7:0] subtype,
                                             credit_t credit, pkt_class_t port);
      pkt_entry_t e;
      e.op      = op;
      e.len     = 2'(len);
      e.dst     = dst;
      e.src     = src;
      e.data    = data;
      e.subtype = subtype;
      e.credit  = credit;
      e.port    = port;
      return e;
   endfunction

   task automatic load_table();
      pkts[0]  = make_entry(op_write, 0, 32'h0000_1000, 32'h0000_2000,
                            word_run(32'hA000_0000), 8'h00, 16'h0000, cls_req);
      pkts[1]  = make_entry(op_read, 0, 32'h0000_1100, 32'h0000_2100,
                            word_run(32'hB000_0000), 8'h00, 16'h0000, cls_req);
      pkts[2]  = make_entry(op_read_resp, 1, 32'h0000_1200, 32'h0000_2200,
                            word_run(32'hC000_0000), 8'h00, 16'h0000, cls_resp);
      pkts[3]  = make_entry(op_link, 0, '0, '0, '0, subtype_crdt_req, 16'h0040, cls_link);
      pkts[4]  = make_entry(op_write_posted, 3, 32'h0000_1300, 32'h0000_2300,
                            word_run(32'hD000_0000), 8'h00, 16'h0000, cls_req);
      pkts[5]  = make_entry(op_link, 0, '0, '0, '0, subtype_crdt_req, 16'h0051, cls_link);
      pkts[6]  = make_entry(op_write_resp, 0, 32'h0000_1400, 32'h0000_2400,
                            word_run(32'hE000_0000), 8'h00, 16'h0000, cls_resp);
      pkts[7]  = make_entry(op_write, 2, 32'h0000_1500, 32'h0000_2500,
                            word_run(32'hF000_0000), 8'h00, 16'h0000, cls_req);
      pkts[8]  = make_entry(op_link, 0, '0, '0, '0, subtype_crdt_resp, 16'h0033, cls_link);
      pkts[9]  = make_entry(op_read_resp, 3, 32'h0000_1600, 32'h0000_2600,
                            word_run(32'h1100_0000), 8'h00, 16'h0000, cls_resp);
      pkts[10] = make_entry(op_write_posted, 1, 32'h0000_1700, 32'h0000_2700,
                            word_run(32'h2200_0000), 8'h00, 16'h0000, cls_req);
      pkts[11] = make_entry(op_link, 0, '0, '0, '0, 8'h22, 16'h7777, cls_link);  // Ignored
      pkts[12] = make_entry(op_write, 3, 32'h0000_1800, 32'h0000_2800,
                            word_run(32'h3300_0000), 8'h00, 16'h0000, cls_req);
   endtask

   //########################################
   // PHY driver and compare tasks
   //########################################
   task automatic send_beat(input beat_t b);
      @(posedge clk);
      #1;
      phy_rxdata = b;
      phy_rxvld  = 1'b1;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      phy_rxvld = 1'b0;
   endtask

   task automatic send_packet(input pkt_entry_t e);
      int i;
      send_beat(make_cmd(e));
      if (e.op != op_link)
      begin
         send_beat(e.dst);
         send_beat(e.src);
      end
      if (has_data(e.op))
         for (i = 0; i <= int'(e.len); i++)
            send_beat(e.data[i*beat_w +: beat_w]);
   endtask

   task automatic check_req(input int idx, input out_pkt_t exp, input logic [cmd_w-1:0] cmd,
                            input addr_t dst, input addr_t src, input data_t data);
      checks++;
      if (cmd !== exp.cmd || dst !== exp.dst || src !== exp.src || data !== exp.data)
      begin
         errors++;
         $display("[FAIL] %0t ns: request packet %0d got cmd %h dst %h src %h data %h",
                  $time, idx, cmd, dst, src, data);
         $display("       expected cmd %h dst %h src %h data %h",
                  exp.cmd, exp.dst, exp.src, exp.data);
      end
      else
         $display("[PASS] request packet %0d, cmd %h", idx, cmd);
   endtask

   task automatic check_resp(input int idx, input out_pkt_t exp, input logic [cmd_w-1:0] cmd,
                             input addr_t dst, input addr_t src, input data_t data);
      checks++;
      if (cmd !== exp.cmd || dst !== exp.dst || src !== exp.src || data !== exp.data)
      begin
         errors++;
         $display("[FAIL] %0t ns: response packet %0d got cmd %h dst %h src %h data %h",
                  $time, idx, cmd, dst, src, data);
         $display("       expected cmd %h dst %h src %h data %h",
                  exp.cmd, exp.dst, exp.src, exp.data);
      end
      else
         $display("[PASS] response packet %0d, cmd %h", idx, cmd);
   endtask

   task automatic check_credit(input string what, input credit_t got, input credit_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
      else
         $display("[PASS] %s = %h", what, got);
   endtask

   //########################################
   // Output monitors, ready and watchdog
   //########################################
   always @(posedge clk)
   begin
      if (req_valid)
      begin
         if (req_held && {req_cmd, req_dstaddr, req_srcaddr, req_data} !== req_hold_val)
         begin
            errors++;
            $display("[FAIL] %0t ns: request fields changed while valid", $time);
         end
         if (req_ready)
         begin
            if (req_exp.size() == 0)
            begin
               errors++;
               $display("Unexpected packet on the request port at %0t ns", $time);
            end
            else
               check_req(req_seen, req_exp.pop_front(), req_cmd, req_dstaddr,
                         req_srcaddr, req_data);
            req_seen++;
            req_held = 1'b0;
         end
         else
         begin
            req_held     = 1'b1;                  // Must hold until taken
            req_hold_val = {req_cmd, req_dstaddr, req_srcaddr, req_data};
         end
      end
      if (resp_valid)
      begin
         if (resp_held && {resp_cmd, resp_dstaddr, resp_srcaddr, resp_data} !== resp_hold_val)
         begin
            errors++;
            $display("[FAIL] %0t ns: response fields changed while valid", $time);
         end
         if (resp_ready)
         begin
            if (resp_exp.size() == 0)
            begin
               errors++;
               $display("Unexpected packet on the response port at %0t ns", $time);
            end
            else
               check_resp(resp_seen, resp_exp.pop_front(), resp_cmd, resp_dstaddr,
                          resp_srcaddr, resp_data);
            resp_seen++;
            resp_held = 1'b0;
         end
         else
         begin
            resp_held     = 1'b1;
            resp_hold_val = {resp_cmd, resp_dstaddr, resp_srcaddr, resp_data};
         end
      end
   end

   always @(posedge clk)
   begin
      #1;
      if (random_ready)
      begin
         req_ready  = ($urandom % 4) != 0;     // Roughly one stall in four
         resp_ready = ($urandom % 3) != 0;
      end
      else
      begin
         req_ready  = 1'b1;
         resp_ready = 1'b0;                    // Response port blocked
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("Timeout: run stopped after %0d cycles without finishing", cycles);
         $display("tests failed");
         $finish;
      end
   end

   //########################################
   // Main sequence
   //########################################
   initial
   begin
      int      i;
      int      req_beats;
      int      resp_beats;
      int      total_beats;
      credit_t exp_rmt_req;
      credit_t exp_rmt_resp;

      void'($urandom(25762));
      nreset             = 1'b0;
      phy_rxdata         = '0;
      phy_rxvld          = 1'b0;
      csr_en             = 1'b1;
      csr_crdt_req_init  = req_init;
      csr_crdt_resp_init = resp_init;
      req_ready          = 1'b1;
      resp_ready         = 1'b0;
      load_table();

      // Expected queues, beat totals and final remote credits
      req_beats    = 0;
      resp_beats   = 0;
      total_beats  = 0;
      exp_rmt_req  = '0;
      exp_rmt_resp = '0;
      for (i = 0; i < n_pkts; i++)
      begin
         total_beats += expected_beats(pkts[i]);
         if (pkts[i].port == cls_req)
         begin
            req_exp.push_back(expected_out(pkts[i]));
            req_beats += expected_beats(pkts[i]);
            n_req++;
         end
         else if (pkts[i].port == cls_resp)
         begin
            resp_exp.push_back(expected_out(pkts[i]));
            resp_beats += expected_beats(pkts[i]);
            n_resp++;
         end
         else if (pkts[i].subtype == 8'h01)
            exp_rmt_req = pkts[i].credit;         // Last one wins
         else if (pkts[i].subtype == 8'h11)
            exp_rmt_resp = pkts[i].credit;
      end
      cycle_limit = 20 * total_beats + 200;

      repeat (10) @(posedge clk);
      #1;
      nreset = 1'b1;

      // Idle state after reset
      checks++;
      if (req_valid !== 1'b0 || resp_valid !== 1'b0)
      begin
         errors++;
         $display("[FAIL] %0t ns: output valid high after reset", $time);
      end
      else
         $display("[PASS] output valids low after reset");
      check_credit("loc_crdt_req after reset", loc_crdt_req, '0);
      check_credit("loc_crdt_resp after reset", loc_crdt_resp, '0);
      check_credit("rmt_crdt_req after reset", rmt_crdt_req, '0);
      check_credit("rmt_crdt_resp after reset", rmt_crdt_resp, '0);

      // Init load while disabled
      csr_en = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      csr_en = 1'b1;
      check_credit("loc_crdt_req after load", loc_crdt_req, req_init);
      check_credit("loc_crdt_resp after load", loc_crdt_resp, resp_init);

      for (i = 0; i < n_pkts; i++)
      begin
         send_packet(pkts[i]);
         if (i % 3 == 2)
            idle_cycle();                         // Gap between some packets
      end
      idle_cycle();
      random_ready = 1'b1;                        // Release both ports

      wait (req_seen >= n_req && resp_seen >= n_resp);
      repeat (2) @(posedge clk);                  // Credits trail reads by a cycle
      #1;
      check_credit("loc_crdt_req after drain", loc_crdt_req, req_init + credit_t'(req_beats));
      check_credit("loc_crdt_resp after drain", loc_crdt_resp,
                   resp_init + credit_t'(resp_beats));
      check_credit("rmt_crdt_req from link", rmt_crdt_req, exp_rmt_req);
      check_credit("rmt_crdt_resp from link", rmt_crdt_resp, exp_rmt_resp);

      $display("%0d checks run, %0d errors", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule
